/* common/cache_pkg.sv */
// Cache geometry constants, index and tag types, and the line fill struct
package cache_pkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  localparam int OFFSET_BITS      = 3;   // 8 byte blocks
  localparam int DEFAULT_IDX_BITS = 7;   // 128 lines
  localparam int TAG_BITS         = 22;  // Covers addresses below 2^32

  typedef logic [DEFAULT_IDX_BITS-1:0] idx_t;
  typedef logic [TAG_BITS-1:0]         tag_t;

  ////////////////////////////////////////
  // Line fill
  ////////////////////////////////////////

  // Written into the arrays at the edge after it is presented, 93 bits
  typedef struct packed {
    idx_t              idx;
    tag_t              tag;
    fetch_pkg::block_t data;
  } cache_fill_t;

endpackage

/* common/fetch_pkg.sv */
// Fetch types: addresses, instruction words, memory bus commands and requests, fetch packets
package fetch_pkg;

  ////////////////////////////////////////
  // Basic widths
  ////////////////////////////////////////

  typedef logic [63:0] addr_t;     // Byte address
  typedef logic [31:0] inst_t;     // One instruction word
  typedef logic [63:0] block_t;    // Memory and cache block
  typedef logic [3:0]  mem_tag_t;  // Zero means no tag

  ////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // 130 bits on the bus
  typedef struct packed {
    bus_cmd_e cmd;
    addr_t    addr;
    block_t   data;   // Store data only
  } bus_req_t;

  ////////////////////////////////////////
  // Fetch output
  ////////////////////////////////////////

  // IF/ID style packet, 97 bits
  typedef struct packed {
    logic  valid;
    addr_t npc;
    inst_t ir;
  } fetch_pkt_t;

  // Alpha no-op, ir of an empty packet
  localparam inst_t NOOP_INST = 32'h47ff_041f;

  localparam addr_t RESET_PC = 64'h0;

endpackage

/* fetch_unit.f */
common/fetch_pkg.sv
common/cache_pkg.sv
rtl/fetch_pc.sv
icache/icache_mem.sv
icache/icache_ctrl.sv
rtl/mem_bus_arbiter.sv
rtl/fetch_unit.sv
verif/fetch_tb_mem.sv
verif/fetch_unit_tb.sv

/* icache/icache_ctrl.sv */
// Instruction cache controller: hit detection, miss request, outstanding tag and line fill
module icache_ctrl #(
  parameter int IDX_BITS = cache_pkg::DEFAULT_IDX_BITS
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  fetch_pkg::addr_t       fetch_addr,
  input  fetch_pkg::mem_tag_t    imem_response,  // Nonzero when the request is taken
  input  fetch_pkg::mem_tag_t    mem2proc_tag,
  input  fetch_pkg::block_t      mem2proc_data,
  input  fetch_pkg::block_t      rd_data,
  input  logic                   rd_valid,
  output logic                   hit,
  output fetch_pkg::block_t      hit_block,
  output fetch_pkg::bus_req_t    imem_req,
  output logic [IDX_BITS-1:0]    rd_idx,
  output cache_pkg::tag_t        rd_tag,
  output cache_pkg::cache_fill_t fill,
  output logic                   fill_en
);
  import fetch_pkg::*;
  import cache_pkg::*;

  // Boot gives the bus one quiet cycle out of reset
  typedef enum logic [1:0] {
    IC_BOOT,
    IC_IDLE,
    IC_WAIT
  } ic_state_e;

  ic_state_e           state;
  mem_tag_t            wait_tag;   // Tag of the outstanding load
  logic [IDX_BITS-1:0] miss_idx;
  tag_t                miss_tag;
  logic                accepted;

  ////////////////////////////////////////
  // Address split and hit
  ////////////////////////////////////////

  assign rd_idx    = fetch_addr[OFFSET_BITS +: IDX_BITS];
  assign rd_tag    = fetch_addr[OFFSET_BITS + IDX_BITS +: TAG_BITS];
  assign hit       = rd_valid;
  assign hit_block = rd_data;

  ////////////////////////////////////////
  // Miss request
  ////////////////////////////////////////

  // Repeats each cycle until the arbiter hands back a tag
  always_comb
  begin
    imem_req.cmd  = (state == IC_IDLE && !rd_valid) ? BUS_LOAD : BUS_NONE;
    imem_req.addr = {fetch_addr[63:OFFSET_BITS], {OFFSET_BITS{1'b0}}};  // Block aligned
    imem_req.data = '0;
  end

  assign accepted = (imem_req.cmd == BUS_LOAD) && (imem_response != '0);

  // Returning block for our tag goes straight into the arrays
  assign fill_en = (state == IC_WAIT) && (mem2proc_tag == wait_tag);
  assign fill    = '{idx: idx_t'(miss_idx), tag: miss_tag, data: mem2proc_data};

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IC_BOOT;
      wait_tag <= '0;
    end
    else
    begin
      case (state)
        IC_BOOT:
        begin
          state <= IC_IDLE;
        end
        IC_IDLE:
        begin
          if (accepted)
          begin
            state    <= IC_WAIT;
            wait_tag <= imem_response;
          end
        end
        default:
        begin
          // Completes even after a redirect moved the PC away
          if (fill_en)
          begin
            state    <= IC_IDLE;
            wait_tag <= '0;
          end
        end
      endcase
    end
  end

  // Line the outstanding load belongs to
  always_ff @(posedge clock)
  begin
    if (accepted)
    begin
      miss_idx <= rd_idx;
      miss_tag <= rd_tag;
    end
  end

  // Arbiter only grants with a real tag
  a_wait_tag_nonzero : assert property (
    @(posedge clock) disable iff (!rst_n)
    state == IC_WAIT |-> wait_tag != '0
  ) else $error("icache waiting on tag zero");

endmodule

/* icache/icache_mem.sv */
// Valid, tag and data arrays of the direct-mapped instruction cache
module icache_mem #(
  parameter int IDX_BITS = cache_pkg::DEFAULT_IDX_BITS
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic [IDX_BITS-1:0]    rd_idx,
  input  cache_pkg::tag_t        rd_tag,
  input  cache_pkg::cache_fill_t fill,
  input  logic                   fill_en,
  output fetch_pkg::block_t      rd_data,
  output logic                   rd_valid
);
  import fetch_pkg::*;
  import cache_pkg::*;

  localparam int LINES = 1 << IDX_BITS;

  logic [LINES-1:0]    valid;
  tag_t                tags  [LINES];
  block_t              data  [LINES];
  logic [IDX_BITS-1:0] wr_idx;

  assign wr_idx = IDX_BITS'(fill.idx);

  // Only the valid bits come out of reset
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid <= '0;
    end
    else if (fill_en)
    begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (fill_en)
    begin
      tags[wr_idx] <= fill.tag;
      data[wr_idx] <= fill.data;
    end
  end

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  assign rd_data  = data[rd_idx];
  assign rd_valid = valid[rd_idx] && (tags[rd_idx] == rd_tag);  // Tag match

endmodule

/* rtl/fetch_pc.sv */
// Program counter with redirect and stall, plus the registered fetch packet
module fetch_pc (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  stall,        // Back-pressure from decode
  input  logic                  redirect,     // Mispredict recovery
  input  fetch_pkg::addr_t      redirect_pc,
  input  logic                  hit,
  input  fetch_pkg::block_t     hit_block,
  output fetch_pkg::addr_t      fetch_addr,
  output fetch_pkg::fetch_pkt_t packet
);
  import fetch_pkg::*;

  addr_t pc_plus4;
  inst_t sel_word;
  logic  advance;

  assign pc_plus4 = fetch_addr + 64'd4;

  // Bit 2 picks the upper word of the block
  assign sel_word = fetch_addr[2] ? hit_block[63:32] : hit_block[31:0];

  assign advance = hit && !stall;  // Always predict not taken

  ////////////////////////////////////////
  // PC register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_addr <= RESET_PC;
    end
    else if (redirect)
    begin
      fetch_addr <= redirect_pc;  // Wins over stall
    end
    else if (advance)
    begin
      fetch_addr <= pc_plus4;
    end
  end

  ////////////////////////////////////////
  // Fetch packet register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      packet <= '{valid: 1'b0, npc: RESET_PC, ir: NOOP_INST};
    end
    else if (redirect)
    begin
      // Squash whatever was fetched on the wrong path
      packet.valid <= 1'b0;
      packet.ir    <= NOOP_INST;
    end
    else if (!stall)
    begin
      packet.valid <= hit;           // Bubble on a miss
      packet.npc   <= pc_plus4;
      packet.ir    <= hit ? sel_word : NOOP_INST;
    end
  end

  // Decode sees the same packet for as long as it stalls
  a_stall_holds_packet : assert property (
    @(posedge clock) disable iff (!rst_n)
    stall && !redirect |=> $stable(packet)
  ) else $error("fetch packet changed under stall");

endmodule

/* rtl/fetch_unit.sv */
// Fetch front end top: PC, instruction cache and memory bus arbiter
module fetch_unit #(
  parameter int IDX_BITS = cache_pkg::DEFAULT_IDX_BITS
) (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  stall,
  input  logic                  redirect,
  input  fetch_pkg::addr_t      redirect_pc,
  input  fetch_pkg::bus_req_t   dmem_req,           // Stands in for the data cache
  input  fetch_pkg::mem_tag_t   mem2proc_response,
  input  fetch_pkg::mem_tag_t   mem2proc_tag,
  input  fetch_pkg::block_t     mem2proc_data,
  output fetch_pkg::bus_req_t   proc2mem,
  output fetch_pkg::mem_tag_t   dmem_response,
  output fetch_pkg::fetch_pkt_t packet
);
  import fetch_pkg::*;
  import cache_pkg::*;

  addr_t               fetch_addr;
  logic                hit;
  block_t              hit_block;
  logic [IDX_BITS-1:0] rd_idx;
  tag_t                rd_tag;
  block_t              rd_data;
  logic                rd_valid;
  cache_fill_t         fill;
  logic                fill_en;
  bus_req_t            imem_req;
  mem_tag_t            imem_response;

  ////////////////////////////////////////
  // PC and fetch packet
  ////////////////////////////////////////

  fetch_pc i_fetch_pc (
    .clock       (clock),
    .rst_n       (rst_n),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .hit         (hit),
    .hit_block   (hit_block),
    .fetch_addr  (fetch_addr),
    .packet      (packet)
  );

  ////////////////////////////////////////
  // Instruction cache
  ////////////////////////////////////////

  icache_ctrl #(.IDX_BITS(IDX_BITS)) i_icache_ctrl (
    .clock         (clock),
    .rst_n         (rst_n),
    .fetch_addr    (fetch_addr),
    .imem_response (imem_response),
    .mem2proc_tag  (mem2proc_tag),
    .mem2proc_data (mem2proc_data),   // Broadcast, tag picks the owner
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .hit           (hit),
    .hit_block     (hit_block),
    .imem_req      (imem_req),
    .rd_idx        (rd_idx),
    .rd_tag        (rd_tag),
    .fill          (fill),
    .fill_en       (fill_en)
  );

  icache_mem #(.IDX_BITS(IDX_BITS)) i_icache_mem (
    .clock    (clock),
    .rst_n    (rst_n),
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .fill     (fill),
    .fill_en  (fill_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  // Bus sharing with the data side
  mem_bus_arbiter i_mem_bus_arbiter (
    .imem_req          (imem_req),
    .dmem_req          (dmem_req),
    .mem2proc_response (mem2proc_response),
    .proc2mem          (proc2mem),
    .imem_response     (imem_response),
    .dmem_response     (dmem_response)
  );

endmodule

/* rtl/mem_bus_arbiter.sv */
// Memory bus arbiter with data-side priority and response routing
module mem_bus_arbiter (
  input  fetch_pkg::bus_req_t imem_req,
  input  fetch_pkg::bus_req_t dmem_req,
  input  fetch_pkg::mem_tag_t mem2proc_response,
  output fetch_pkg::bus_req_t proc2mem,
  output fetch_pkg::mem_tag_t imem_response,
  output fetch_pkg::mem_tag_t dmem_response
);
  import fetch_pkg::*;

  logic dmem_active;

  ////////////////////////////////////////
  // Grant and routing
  ////////////////////////////////////////

  always_comb
  begin
    dmem_active = (dmem_req.cmd != BUS_NONE);  // Data side always wins

    if (dmem_active)
    begin
      proc2mem      = dmem_req;
      dmem_response = mem2proc_response;
      imem_response = '0;                       // Fetch retries next cycle
    end
    else
    begin
      proc2mem      = imem_req;
      dmem_response = '0;
      imem_response = mem2proc_response;
    end

    // Acceptance tag goes to one side only
    a_one_owner : assert (!((imem_response != '0) && (dmem_response != '0)))
      else $error("bus response routed to both sides");
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the fetch unit simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module fetch_unit_tb \
  -f fetch_unit.f \
  -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi

/* verif/fetch_tb_mem.sv */
// Tagged memory model with random accept and latency, block content function and LFSR source
module fetch_tb_mem (
  input  logic                clock,
  input  logic                rst_n,
  input  fetch_pkg::bus_req_t proc2mem,
  output fetch_pkg::mem_tag_t mem2proc_response,
  output fetch_pkg::mem_tag_t mem2proc_tag,
  output fetch_pkg::block_t   mem2proc_data
);
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic [31:0] lfsr = 32'h29f8;
  logic        coin;        // Accept decision for this cycle
  logic        busy;        // One transaction in flight
  mem_tag_t    next_tag;
  mem_tag_t    pend_tag;
  addr_t       pend_addr;
  logic [2:0]  count;

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      if (lfsr[0])
        lfsr = (lfsr >> 1) ^ LFSR_TAPS;
      else
        lfsr = lfsr >> 1;
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Content of a block, mixed from the whole address
  function automatic block_t block_content(input addr_t a);
    return {a[31:0] ^ a[63:32] ^ 32'h9e37_79b9, (a[31:0] * 32'd3) ^ 32'h0bad_f00d};
  endfunction

  ////////////////////////////////////////
  // Acceptance and return
  ////////////////////////////////////////

  always_comb
  begin
    mem2proc_response = (proc2mem.cmd != BUS_NONE && !busy && coin) ? next_tag : '0;
  end

  always @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      coin          <= 1'b0;
      busy          <= 1'b0;
      next_tag      <= 4'd1;
      pend_tag      <= '0;
      pend_addr     <= '0;
      count         <= '0;
      mem2proc_tag  <= '0;
      mem2proc_data <= '0;
    end
    else
    begin
      mem2proc_tag <= '0;               // Tag lives for one cycle
      coin         <= rand_bits(1) != 32'd0;
      if (mem2proc_response != '0)
      begin
        busy      <= 1'b1;
        pend_tag  <= next_tag;
        pend_addr <= proc2mem.addr;
        count     <= 3'(rand_bits(3));  // 1 to 8 cycles
        next_tag  <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      else if (busy)
      begin
        if (count == 3'd0)
        begin
          mem2proc_tag  <= pend_tag;
          mem2proc_data <= block_content(pend_addr);
          busy          <= 1'b0;
        end
        else
        begin
          count <= count - 3'd1;
        end
      end
    end
  end

endmodule

/* verif/fetch_unit_tb.sv */
// Fetch unit testbench with clock, reset, random stimulus, reference checks and watchdog
module fetch_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam int CLOCK_PERIOD    = 4;
  localparam int PLANNED_FETCHES = 334;

  logic       clock;
  logic       rst_n;
  logic       stall;
  logic       redirect;
  addr_t      redirect_pc;
  bus_req_t   dmem_req;
  mem_tag_t   mem2proc_response;
  mem_tag_t   mem2proc_tag;
  block_t     mem2proc_data;
  bus_req_t   proc2mem;
  mem_tag_t   dmem_response;
  fetch_pkt_t packet;

  // Reference state
  addr_t      expected_npc = RESET_PC + 64'd4;
  int         fetch_count = 0;
  logic       stall_prev = 1'b0;
  logic       redirect_prev = 1'b0;
  addr_t      target_prev = '0;
  fetch_pkt_t last_pkt;
  logic       refetch_check = 1'b0;

  fetch_unit i_fetch_unit (
    .clock             (clock),
    .rst_n             (rst_n),
    .stall             (stall),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .dmem_req          (dmem_req),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem          (proc2mem),
    .dmem_response     (dmem_response),
    .packet            (packet)
  );

  fetch_tb_mem i_mem (
    .clock             (clock),
    .rst_n             (rst_n),
    .proc2mem          (proc2mem),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data)
  );

  initial
  begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [129:0] got,
                             input logic [129:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Instruction word that sits at a byte address
  function automatic inst_t expected_word(input addr_t a);
    block_t blk;
    blk = i_mem.block_content({a[63:3], 3'b000});
    return a[2] ? blk[63:32] : blk[31:0];
  endfunction

  task automatic wait_packets(input int n);
    int target;
    target = fetch_count + n;
    while (fetch_count < target)
      @(posedge clock);
    #1;
  endtask

  ////////////////////////////////////////
  // Monitor sampled mid cycle
  ////////////////////////////////////////

  always @(negedge clock)
  begin
    if (!rst_n)
    begin
      check_value("packet.valid", 130'(packet.valid), 130'(1'b0));
      check_value("proc2mem.cmd", 130'(proc2mem.cmd), 130'(BUS_NONE));
    end
    else
    begin
      if (redirect_prev)
      begin
        check_value("packet.valid", 130'(packet.valid), 130'(1'b0));  // Squashed
        expected_npc = target_prev + 64'd4;
      end
      else if (stall_prev)
      begin
        check_value("packet", 130'(packet), 130'(last_pkt));
      end
      else if (packet.valid)
      begin
        check_value("packet.npc", 130'(packet.npc), 130'(expected_npc));
        check_value("packet.ir", 130'(packet.ir), 130'(expected_word(expected_npc - 64'd4)));
        expected_npc = expected_npc + 64'd4;
        fetch_count++;
      end
      if (dmem_req.cmd != BUS_NONE)
      begin
        check_value("proc2mem", 130'(proc2mem), 130'(dmem_req));
        check_value("dmem_response", 130'(dmem_response), 130'(mem2proc_response));
      end
      else
      begin
        check_value("dmem_response", 130'(dmem_response), 130'(4'd0));
      end
      if (refetch_check)
      begin
        check_value("proc2mem.cmd", 130'(proc2mem.cmd), 130'(BUS_NONE));  // Lines should hit
      end
    end
    stall_prev    = stall;
    redirect_prev = redirect;
    target_prev   = redirect_pc;
    last_pkt      = packet;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    int          target;
    rst_n       = 1'b0;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    dmem_req    = '{cmd: BUS_NONE, addr: '0, data: '0};
    repeat (16) @(posedge clock);
    #1 rst_n = 1'b1;

    wait_packets(40);  // Straight line fetch

    // Random stall, redirect and data traffic
    target = fetch_count + 150;
    while (fetch_count < target)
    begin
      @(posedge clock);
      #1;
      stall = i_mem.rand_bits(2) == 32'd0;
      r = i_mem.rand_bits(5);
      redirect = r == 32'd0;
      r = i_mem.rand_bits(8);
      redirect_pc = 64'({r[7:0], 2'b00});  // Stays inside the cache span
      r = i_mem.rand_bits(3);
      if (r == 32'd0)
      begin
        r = i_mem.rand_bits(8);
        dmem_req = '{cmd: BUS_LOAD, addr: 64'h1000_0000 + 64'({r[7:0], 3'b000}), data: '0};
      end
      else
      begin
        dmem_req = '{cmd: BUS_NONE, addr: '0, data: '0};
      end
    end
    @(posedge clock);
    #1;
    stall    = 1'b0;
    redirect = 1'b0;
    dmem_req = '{cmd: BUS_NONE, addr: '0, data: '0};
    wait_packets(20);

    // First pass over a region and a second pass from the cache
    @(posedge clock);
    #1 redirect = 1'b1;
    redirect_pc = 64'h0;
    @(posedge clock);
    #1 redirect = 1'b0;
    wait_packets(64);
    @(posedge clock);
    #1 redirect = 1'b1;
    @(posedge clock);
    #1 redirect = 1'b0;
    refetch_check = 1'b1;
    wait_packets(60);
    refetch_check = 1'b0;

    $display("TEST RESULT: PASS");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(PLANNED_FETCHES * 40 * CLOCK_PERIOD);
    $display("Timeout at %0t after %0d packets", $time, fetch_count);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule
